// ==== sim/sa_tb.sv ====
`timescale 1ns/1ns
`default_nettype none

module sa_tb;

    localparam int max_steps = 32;
    localparam int idle_cycles = 3 * sa_pkg::array_dim;
    localparam int check_timeout = 8;

    logic                                clk;
    logic                                channel_out_reset;
    logic                                en;
    sa_pkg::sa_mode_e                    mode;
    logic [sa_pkg::row_in_width-1:0]     row_in;
    logic [sa_pkg::column_in_width-1:0]  column_in;
    logic                                channel_out_en;
    logic [sa_pkg::out_width-1:0]        out;

    // steps fed in the current test
    logic [sa_pkg::row_in_width-1:0]     step_row [max_steps];
    logic [sa_pkg::column_in_width-1:0]  step_column [max_steps];
    int                                  n_steps;

    // stimulus to compare process
    logic                                check_valid;
    logic [sa_pkg::out_width-1:0]        check_expected;
    int                                  checks_issued;
    int                                  checks_done;
    int                                  test_checks;
    int                                  test_errors;
    int                                  total_errors;
    int                                  tests_run;
    int                                  tests_failed;
    string                               test_name;
    integer                              seed;

    sa_top u_sa_top (
        .clk               (clk),
        .channel_out_reset (channel_out_reset),
        .en                (en),
        .mode              (mode),
        .row_in            (row_in),
        .column_in         (column_in),
        .channel_out_en    (channel_out_en),
        .out               (out)
    );

    always #20 clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////////////////////////////

    // expected drain word of one PE row over the stored steps
    function automatic logic [sa_pkg::out_width-1:0] expected_row(
        input sa_pkg::sa_mode_e step_mode,
        input int row,
        input int count
    );
        logic [sa_pkg::out_width-1:0]           result;
        logic signed [sa_pkg::weight_width-1:0] weight;
        logic [sa_pkg::pixel_width-1:0]         pixel [2];
        logic [sa_pkg::acc88_width-1:0]         lane88 [2];
        logic [sa_pkg::acc18_width-1:0]         lane18 [4];
        int                                     prod;
        int                                     base;
        result = '0;
        for (int c = 0; c < sa_pkg::array_dim; c++) begin
            base = c * sa_pkg::pe_out_width;
            for (int i = 0; i < 2; i++) begin
                lane88[i] = '0;
            end
            for (int i = 0; i < 4; i++) begin
                lane18[i] = '0;
            end
            for (int k = 0; k < count; k++) begin
                weight = step_row[k][row*8 +: 8];
                pixel[0] = step_column[k][c*16 +: 8];
                pixel[1] = step_column[k][c*16+8 +: 8];
                for (int p = 0; p < 2; p++) begin
                    // signed weight times unsigned pixel
                    prod = int'(weight) * int'(pixel[p]);
                    lane88[p] = lane88[p] + prod[sa_pkg::acc88_width-1:0];
                    // bit s of the weight byte set means minus one
                    for (int s = 0; s < 2; s++) begin
                        if (weight[s]) begin
                            lane18[s*2+p] = lane18[s*2+p] - {8'h00, pixel[p]};
                        end else begin
                            lane18[s*2+p] = lane18[s*2+p] + {8'h00, pixel[p]};
                        end
                    end
                end
            end
            if (step_mode == sa_pkg::mode_int8) begin
                for (int i = 0; i < 2; i++) begin
                    result[base + i*sa_pkg::acc88_width +: sa_pkg::acc88_width] = lane88[i];
                end
            end else begin
                for (int i = 0; i < 4; i++) begin
                    result[base + i*sa_pkg::acc18_width +: sa_pkg::acc18_width] = lane18[i];
                end
            end
        end
        return result;
    endfunction

    // out sampled on the edge still shows the row of the closing cycle
    always @(posedge clk) begin
        if (check_valid) begin
            test_checks++;
            assert (out === check_expected) else begin
                $display("MISMATCH test %s: expected %h, actual %h",
                         test_name, check_expected, out);
                test_errors++;
                total_errors++;
            end
            checks_done++;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // stimulus tasks starting and ending just after a falling edge
    ////////////////////////////////////////////////////////////////////////////

    task automatic start_test(input string name, input sa_pkg::sa_mode_e test_mode);
        test_name = name;
        test_checks = 0;
        test_errors = 0;
        n_steps = 0;
        en = 1'b0;
        channel_out_en = 1'b0;
        row_in = '0;
        column_in = '0;
        mode = test_mode;
        channel_out_reset = 1'b1;
        repeat (3) @(negedge clk);
        channel_out_reset = 1'b0;
    endtask

    task automatic feed_step(input logic [31:0] row_word, input logic [63:0] column_word);
        en = 1'b1;
        row_in = row_word;
        column_in = column_word;
        step_row[n_steps] = row_word;
        step_column[n_steps] = column_word;
        n_steps++;
        @(negedge clk);
        en = 1'b0;
    endtask

    task automatic feed_random_step();
        feed_step($random(seed), {$random(seed), $random(seed)});
    endtask

    task automatic idle(input int cycles);
        en = 1'b0;
        repeat (cycles) @(negedge clk);
    endtask

    task automatic issue_check(input logic drain, input logic [255:0] expected);
        channel_out_en = drain;
        check_expected = expected;
        check_valid = 1'b1;
        checks_issued++;
        @(negedge clk);
        check_valid = 1'b0;
    endtask

    task automatic drain_rows(input int first_row, input int rows);
        for (int i = 0; i < rows; i++) begin
            issue_check(1'b1, expected_row(mode, (first_row + i) % sa_pkg::array_dim, n_steps));
        end
    endtask

    task automatic end_test();
        int waited;
        channel_out_en = 1'b0;
        check_valid = 1'b0;
        waited = 0;
        while (checks_done != checks_issued && waited < check_timeout) begin
            @(negedge clk);
            waited++;
        end
        if (checks_done != checks_issued) begin
            $display("timeout: compare process did not finish in test %s", test_name);
            test_errors++;
            total_errors++;
        end
        tests_run++;
        if (test_errors != 0) begin
            tests_failed++;
        end
        $display("test %s: %s, %0d checks, %0d errors", test_name,
                 (test_errors == 0) ? "pass" : "fail", test_checks, test_errors);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // test sequence
    ////////////////////////////////////////////////////////////////////////////

    initial begin
        clk = 1'b0;
        channel_out_reset = 1'b1;
        en = 1'b0;
        mode = sa_pkg::mode_int8;
        row_in = '0;
        column_in = '0;
        channel_out_en = 1'b0;
        check_valid = 1'b0;
        check_expected = '0;
        checks_issued = 0;
        checks_done = 0;
        total_errors = 0;
        tests_run = 0;
        tests_failed = 0;
        seed = 44;
        @(negedge clk);

        start_test("reset_state", sa_pkg::mode_int8);
        issue_check(1'b0, '0);
        issue_check(1'b0, '0);
        idle(idle_cycles);
        drain_rows(0, sa_pkg::array_dim);
        end_test();

        // weights -128, -3, 5, 127 against extreme pixels
        start_test("int8_single_step", sa_pkg::mode_int8);
        feed_step(32'h7f05fd80, 64'h0203_7f00_80ff_ff01);
        idle(idle_cycles);
        drain_rows(0, sa_pkg::array_dim);
        end_test();

        start_test("int8_random", sa_pkg::mode_int8);
        for (int k = 0; k < 20; k++) begin
            feed_random_step();
        end
        idle(idle_cycles);
        drain_rows(0, sa_pkg::array_dim);
        end_test();

        start_test("sign_random", sa_pkg::mode_sign);
        for (int k = 0; k < 20; k++) begin
            feed_random_step();
        end
        idle(idle_cycles);
        drain_rows(0, sa_pkg::array_dim);
        end_test();

        // idle gaps between steps with a pause and a wrap in the drain
        start_test("gaps_and_drain", sa_pkg::mode_int8);
        for (int k = 0; k < 12; k++) begin
            feed_random_step();
            idle($random(seed) & 3);
        end
        idle(idle_cycles);
        drain_rows(0, 2);
        issue_check(1'b0, '0);
        issue_check(1'b0, '0);
        drain_rows(2, 2);
        drain_rows(0, sa_pkg::array_dim);
        end_test();

        $display("tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, total_errors);
        if (total_errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== source/sa_operand_skew.sv ====
`timescale 1ns/1ns
`default_nettype none

module sa_operand_skew (
    input  wire                                 clk,
    input  wire                                 channel_out_reset,
    input  wire                                 en,
    input  wire  [sa_pkg::row_in_width-1:0]     row_in,
    input  wire  [sa_pkg::column_in_width-1:0]  column_in,
    output logic [sa_pkg::row_in_width-1:0]     skewed_row,
    output logic [sa_pkg::array_dim-1:0]        valid_row,
    output logic [sa_pkg::column_in_width-1:0]  skewed_column,
    output logic [sa_pkg::array_dim-1:0]        valid_column
);

    ////////////////////////////////////////////////////////////////////////////
    // triangular delay lines
    ////////////////////////////////////////////////////////////////////////////

    // lane k holds row k and column k, both delayed by k cycles
    for (genvar k = 0; k < sa_pkg::array_dim; k++) begin : g_lane
        logic [sa_pkg::skew_lane_width-1:0] lane_in;
        logic [sa_pkg::skew_lane_width-1:0] lane_out;

        assign lane_in = {
            en,
            row_in[k*sa_pkg::weight_width +: sa_pkg::weight_width],
            column_in[k*sa_pkg::pixel_pair_width +: sa_pkg::pixel_pair_width]
        };

        if (k == 0) begin : g_direct
            // first row and column need no delay
            assign lane_out = lane_in;
        end else begin : g_delay
            logic [sa_pkg::skew_lane_width-1:0] stage [k];

            always_ff @(posedge clk) begin
                if (channel_out_reset) begin
                    for (int i = 0; i < k; i++) begin
                        stage[i] <= '0;
                    end
                end else begin
                    stage[0] <= lane_in;
                    for (int i = 1; i < k; i++) begin
                        stage[i] <= stage[i-1];
                    end
                end
            end

            assign lane_out = stage[k-1];
        end

        // unpack the delayed lane
        assign valid_row[k] = lane_out[sa_pkg::skew_lane_width-1];
        assign valid_column[k] = lane_out[sa_pkg::skew_lane_width-1];

        assign skewed_row[k*sa_pkg::weight_width +: sa_pkg::weight_width] =
            lane_out[sa_pkg::pixel_pair_width +: sa_pkg::weight_width];

        assign skewed_column[k*sa_pkg::pixel_pair_width +: sa_pkg::pixel_pair_width] =
            lane_out[sa_pkg::pixel_pair_width-1:0];
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    // lane 0 strobes follow en in the same cycle and stay known
    a_lane0_strobe : assert property (
        @(posedge clk) disable iff (channel_out_reset)
        (valid_row[0] == en) && (valid_column[0] == en)
            && !$isunknown({valid_row, valid_column})
    ) else $error("skew lane 0 strobe does not follow en");

endmodule

`default_nettype wire

// ==== source/sa_pe.sv ====
`timescale 1ns/1ns
`default_nettype none

module sa_pe (
    input  wire                                 clk,
    input  wire                                 channel_out_reset,
    input  wire  sa_pkg::sa_mode_e              mode,
    input  wire  [sa_pkg::weight_width-1:0]     left,
    input  wire                                 left_valid,
    input  wire  [sa_pkg::pixel_pair_width-1:0] up,
    output logic [sa_pkg::weight_width-1:0]     right,
    output logic                                right_valid,
    output logic [sa_pkg::pixel_pair_width-1:0] bottom,
    output logic [sa_pkg::pe_out_width-1:0]     acc
);

    logic        [sa_pkg::pixel_width-1:0]  pixel0;
    logic        [sa_pkg::pixel_width-1:0]  pixel1;
    logic signed [sa_pkg::mult_a_width-1:0] packed_pixels;
    logic signed [sa_pkg::mult_p_width-1:0] product;
    logic signed [sa_pkg::pack_shift-1:0]   lane_lo;
    logic signed [sa_pkg::mult_p_width-1:0] lane_hi_wide;
    logic signed [sa_pkg::pack_shift-1:0]   lane_hi;
    logic        [sa_pkg::acc88_width-1:0]  int8_term [sa_pkg::int8_lanes];
    logic        [sa_pkg::acc18_width-1:0]  sign_term [sa_pkg::sign_lanes];
    logic        [sa_pkg::sign_lanes-1:0]   sign_neg;
    logic        [sa_pkg::acc88_width-1:0]  acc88 [sa_pkg::int8_lanes];
    logic        [sa_pkg::acc18_width-1:0]  acc18 [sa_pkg::sign_lanes];

    // operands move one PE per cycle
    always_ff @(posedge clk) begin
        if (channel_out_reset) begin
            right <= '0;
            right_valid <= 1'b0;
            bottom <= '0;
        end else begin
            right <= left;
            right_valid <= left_valid;
            bottom <= up;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // mode 0 packed multiply
    ////////////////////////////////////////////////////////////////////////////

    assign pixel0 = up[sa_pkg::pixel_width-1:0];
    assign pixel1 = up[sa_pkg::pixel_pair_width-1:sa_pkg::pixel_width];

    assign packed_pixels = {
        1'b0, pixel1, {(sa_pkg::pack_shift - sa_pkg::pixel_width){1'b0}}, pixel0
    };

    // one multiply gives pixel1*w << 16 plus pixel0*w
    assign product = packed_pixels * $signed(left);

    // low product fits 16 signed bits, its sign borrows from the high lane
    assign lane_lo = product[sa_pkg::pack_shift-1:0];
    assign lane_hi_wide = (product - lane_lo) >>> sa_pkg::pack_shift;
    assign lane_hi = lane_hi_wide[sa_pkg::pack_shift-1:0];

    assign int8_term[0] = {
        {(sa_pkg::acc88_width - sa_pkg::pack_shift){lane_lo[sa_pkg::pack_shift-1]}}, lane_lo
    };
    assign int8_term[1] = {
        {(sa_pkg::acc88_width - sa_pkg::pack_shift){lane_hi[sa_pkg::pack_shift-1]}}, lane_hi
    };

    ////////////////////////////////////////////////////////////////////////////
    // mode 1 sign terms
    ////////////////////////////////////////////////////////////////////////////

    // lanes go p0*s0, p1*s0, p0*s1, p1*s1
    always_comb begin
        for (int i = 0; i < sa_pkg::sign_lanes; i++) begin
            sign_term[i] = {
                {(sa_pkg::acc18_width - sa_pkg::pixel_width){1'b0}},
                (i % 2 == 0) ? pixel0 : pixel1
            };
            sign_neg[i] = (i < 2) ? left[0] : left[1];
        end
    end

    // accumulate on a valid weight, lanes wrap
    always_ff @(posedge clk) begin
        if (channel_out_reset) begin
            for (int i = 0; i < sa_pkg::int8_lanes; i++) begin
                acc88[i] <= '0;
            end
            for (int i = 0; i < sa_pkg::sign_lanes; i++) begin
                acc18[i] <= '0;
            end
        end else if (left_valid) begin
            if (mode == sa_pkg::mode_int8) begin
                for (int i = 0; i < sa_pkg::int8_lanes; i++) begin
                    acc88[i] <= acc88[i] + int8_term[i];
                end
            end else begin
                for (int i = 0; i < sa_pkg::sign_lanes; i++) begin
                    acc18[i] <= sign_neg[i] ? acc18[i] - sign_term[i]
                                            : acc18[i] + sign_term[i];
                end
            end
        end
    end

    // result field, mode 0 keeps the upper bits zero
    always_comb begin
        acc = '0;
        if (mode == sa_pkg::mode_int8) begin
            for (int i = 0; i < sa_pkg::int8_lanes; i++) begin
                acc[i*sa_pkg::acc88_width +: sa_pkg::acc88_width] = acc88[i];
            end
        end else begin
            for (int i = 0; i < sa_pkg::sign_lanes; i++) begin
                acc[i*sa_pkg::acc18_width +: sa_pkg::acc18_width] = acc18[i];
            end
        end
    end

    a_mode_stable : assert property (
        @(posedge clk) disable iff (channel_out_reset)
        left_valid |-> $stable(mode)
    ) else $error("mode changed during accumulation");

endmodule

`default_nettype wire

// ==== source/sa_pe_array.sv ====
`timescale 1ns/1ns
`default_nettype none

module sa_pe_array (
    input  wire                                 clk,
    input  wire                                 channel_out_reset,
    input  wire  sa_pkg::sa_mode_e              mode,
    input  wire  [sa_pkg::row_in_width-1:0]     skewed_row,
    input  wire  [sa_pkg::array_dim-1:0]        valid_row,
    input  wire  [sa_pkg::column_in_width-1:0]  skewed_column,
    input  wire  [sa_pkg::array_dim-1:0]        valid_column,
    output logic [sa_pkg::array_dim*sa_pkg::out_width-1:0] acc_grid
);

    // forwarded outputs of every PE
    logic [sa_pkg::weight_width-1:0]     weight_link [sa_pkg::array_dim][sa_pkg::array_dim];
    logic                                valid_link  [sa_pkg::array_dim][sa_pkg::array_dim];
    logic [sa_pkg::pixel_pair_width-1:0] pixel_link  [sa_pkg::array_dim][sa_pkg::array_dim];

    for (genvar r = 0; r < sa_pkg::array_dim; r++) begin : g_row
        for (genvar c = 0; c < sa_pkg::array_dim; c++) begin : g_col
            logic [sa_pkg::weight_width-1:0]     pe_left;
            logic                                pe_left_valid;
            logic [sa_pkg::pixel_pair_width-1:0] pe_up;

            // weights enter at column 0 and move right
            if (c == 0) begin : g_row_entry
                assign pe_left = skewed_row[r*sa_pkg::weight_width +: sa_pkg::weight_width];
                assign pe_left_valid = valid_row[r];
            end else begin : g_row_chain
                assign pe_left = weight_link[r][c-1];
                assign pe_left_valid = valid_link[r][c-1];
            end

            // pixels enter at row 0 and move down
            if (r == 0) begin : g_col_entry
                assign pe_up =
                    skewed_column[c*sa_pkg::pixel_pair_width +: sa_pkg::pixel_pair_width];

                // along row 0 the weight strobe must meet the pixel strobe
                a_strobe_align : assert property (
                    @(posedge clk) disable iff (channel_out_reset)
                    pe_left_valid == valid_column[c]
                ) else $error("row and column strobes out of step at column %0d", c);
            end else begin : g_col_chain
                assign pe_up = pixel_link[r-1][c];
            end

            sa_pe u_pe (
                .clk               (clk),
                .channel_out_reset (channel_out_reset),
                .mode              (mode),
                .left              (pe_left),
                .left_valid        (pe_left_valid),
                .up                (pe_up),
                .right             (weight_link[r][c]),
                .right_valid       (valid_link[r][c]),
                .bottom            (pixel_link[r][c]),
                .acc               (acc_grid[r*sa_pkg::out_width + c*sa_pkg::pe_out_width
                                             +: sa_pkg::pe_out_width])
            );
        end
    end

endmodule

`default_nettype wire

// ==== source/sa_pkg.sv ====
`default_nettype none

package sa_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // array geometry
    ////////////////////////////////////////////////////////////////////////////

    localparam int array_dim = 4;

    // drain counter walks the rows
    localparam int row_counter_width = 2;

    ////////////////////////////////////////////////////////////////////////////
    // operand lanes
    ////////////////////////////////////////////////////////////////////////////

    localparam int weight_width = 8;
    localparam int pixel_width = 8;

    // two unsigned pixels per column lane, pixel0 in the low byte
    localparam int pixel_pair_width = 2 * pixel_width;

    localparam int row_in_width = array_dim * weight_width;
    localparam int column_in_width = array_dim * pixel_pair_width;

    // strobe, weight and pixel pair move through one skew stage together
    localparam int skew_lane_width = 1 + weight_width + pixel_pair_width;

    ////////////////////////////////////////////////////////////////////////////
    // packed multiply and accumulators
    ////////////////////////////////////////////////////////////////////////////

    // pixel1 sits this far above pixel0 in the multiplicand
    localparam int pack_shift = 16;

    // extra top bit keeps the packed multiplicand positive when signed
    localparam int mult_a_width = pack_shift + pixel_width + 1;
    localparam int mult_p_width = mult_a_width + weight_width;

    localparam int acc88_width = 24;
    localparam int acc18_width = 16;
    localparam int int8_lanes = 2;
    localparam int sign_lanes = 4;

    localparam int pe_out_width = 64;
    localparam int out_width = array_dim * pe_out_width;

    ////////////////////////////////////////////////////////////////////////////
    // operating mode
    ////////////////////////////////////////////////////////////////////////////

    typedef enum logic {
        mode_int8 = 1'b0,
        mode_sign = 1'b1
    } sa_mode_e;

endpackage

`default_nettype wire

// ==== source/sa_row_drain.sv ====
`timescale 1ns/1ns
`default_nettype none

module sa_row_drain (
    input  wire                                              clk,
    input  wire                                              channel_out_reset,
    input  wire                                              channel_out_en,
    input  wire  [sa_pkg::array_dim*sa_pkg::out_width-1:0]   acc_grid,
    output logic [sa_pkg::out_width-1:0]                     out
);

    logic [sa_pkg::row_counter_width-1:0] row_counter;
    logic [sa_pkg::row_counter_width-1:0] row_counter_next;
    logic                                 last_row;

    ////////////////////////////////////////////////////////////////////////////
    // row counter
    ////////////////////////////////////////////////////////////////////////////

    assign last_row = (row_counter == sa_pkg::row_counter_width'(sa_pkg::array_dim - 1));

    always_comb begin
        if (last_row) begin
            row_counter_next = '0;
        end else begin
            row_counter_next = row_counter + 1'b1;
        end
    end

    // one row per drain cycle and held while paused
    always_ff @(posedge clk) begin
        if (channel_out_reset) begin
            row_counter <= '0;
        end else if (channel_out_en) begin
            row_counter <= row_counter_next;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // output select
    ////////////////////////////////////////////////////////////////////////////

    // column c of the row lands in field c
    always_comb begin
        if (channel_out_en) begin
            out = acc_grid[row_counter*sa_pkg::out_width +: sa_pkg::out_width];
        end else begin
            out = '0;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////////////////////////////

    a_row_range : assert property (
        @(posedge clk) disable iff (channel_out_reset)
        row_counter < sa_pkg::array_dim
    ) else $error("row_counter out of range");

endmodule

`default_nettype wire

// ==== source/sa_top.sv ====
`timescale 1ns/1ns
`default_nettype none

module sa_top (
    input  wire                                 clk,
    input  wire                                 channel_out_reset,
    input  wire                                 en,
    input  wire  sa_pkg::sa_mode_e              mode,
    input  wire  [sa_pkg::row_in_width-1:0]     row_in,
    input  wire  [sa_pkg::column_in_width-1:0]  column_in,
    input  wire                                 channel_out_en,
    output logic [sa_pkg::out_width-1:0]        out
);

    logic [sa_pkg::row_in_width-1:0]               skewed_row;
    logic [sa_pkg::array_dim-1:0]                  valid_row;
    logic [sa_pkg::column_in_width-1:0]            skewed_column;
    logic [sa_pkg::array_dim-1:0]                  valid_column;
    logic [sa_pkg::array_dim*sa_pkg::out_width-1:0] acc_grid;

    // operands skewed so row r and column c meet in step
    sa_operand_skew u_skew (
        .clk               (clk),
        .channel_out_reset (channel_out_reset),
        .en                (en),
        .row_in            (row_in),
        .column_in         (column_in),
        .skewed_row        (skewed_row),
        .valid_row         (valid_row),
        .skewed_column     (skewed_column),
        .valid_column      (valid_column)
    );

    sa_pe_array u_array (
        .clk               (clk),
        .channel_out_reset (channel_out_reset),
        .mode              (mode),
        .skewed_row        (skewed_row),
        .valid_row         (valid_row),
        .skewed_column     (skewed_column),
        .valid_column      (valid_column),
        .acc_grid          (acc_grid)
    );

    // results leave one PE row per drain cycle
    sa_row_drain u_drain (
        .clk               (clk),
        .channel_out_reset (channel_out_reset),
        .channel_out_en    (channel_out_en),
        .acc_grid          (acc_grid),
        .out               (out)
    );

endmodule

`default_nettype wire

// ==== vlog.f ====
source/sa_pkg.sv
source/sa_operand_skew.sv
source/sa_pe.sv
source/sa_pe_array.sv
source/sa_row_drain.sv
source/sa_top.sv
sim/sa_tb.sv
